// ==== all.f ====
+incdir+sim
src/tl_pkg.sv
src/dcache_tag.sv
src/store_buffer.sv
src/tl_stage.sv
src/tl_top.sv
sim/tl_assert.sv
sim/tl_tb.sv

// ==== Bender.yml ====
package:
  name: tl_stage

sources:
  - src/tl_pkg.sv
  - src/dcache_tag.sv
  - src/store_buffer.sv
  - src/tl_stage.sv
  - src/tl_top.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tl_assert.sv
      - sim/tl_tb.sv

// ==== sim/tl_tb_table.svh ====
`ifndef TL_TB_TABLE_SVH
`define TL_TB_TABLE_SVH

typedef enum logic [1:0] {
    OP_IDLE,
    OP_LOAD,
    OP_STORE
} op_kind_e;

// Columns: kind, address, store data, type, sb_hit, forwarded data, stall
typedef struct packed {
    op_kind_e             kind;
    logic [ADDR_SIZE-1:0] addr;
    logic [WORD_SIZE-1:0] data;
    memop_type_e          memop_type;
    logic                 exp_sb_hit;
    logic [WORD_SIZE-1:0] exp_data;
    logic                 exp_stall;
} stim_row_t;

localparam int N_ROWS = 24;

localparam stim_row_t STIM_TABLE [N_ROWS] = '{
    '{OP_LOAD,  32'h0000_1000, 32'h0000_0000, WORD, 1'b0, 32'h0000_0000, 1'b1}, // Cold line
    '{OP_LOAD,  32'h0000_1004, 32'h0000_0000, WORD, 1'b0, 32'h0000_0000, 1'b0},
    '{OP_STORE, 32'h0000_1008, 32'hA5A5_0001, WORD, 1'b0, 32'h0000_0000, 1'b0},
    '{OP_LOAD,  32'h0000_1008, 32'h0000_0000, WORD, 1'b1, 32'hA5A5_0001, 1'b0}, // Forwarded
    '{OP_STORE, 32'h0000_100A, 32'h0000_BEEF, HALF, 1'b0, 32'h0000_0000, 1'b0},
    '{OP_LOAD,  32'h0000_1008, 32'h0000_0000, WORD, 1'b0, 32'h0000_0000, 1'b0}, // Partial match
    '{OP_IDLE,  32'h0000_0000, 32'h0000_0000, WORD, 1'b0, 32'h0000_0000, 1'b0},
    '{OP_IDLE,  32'h0000_0000, 32'h0000_0000, WORD, 1'b0, 32'h0000_0000, 1'b0},
    '{OP_IDLE,  32'h0000_0000, 32'h0000_0000, WORD, 1'b0, 32'h0000_0000, 1'b0},
    '{OP_STORE, 32'h0000_2010, 32'h1111_2222, WORD, 1'b0, 32'h0000_0000, 1'b0}, // Store miss
    '{OP_STORE, 32'h0000_2014, 32'h3333_4444, WORD, 1'b0, 32'h0000_0000, 1'b0},
    '{OP_LOAD,  32'h0000_3020, 32'h0000_0000, WORD, 1'b0, 32'h0000_0000, 1'b1}, // Other tag
    '{OP_IDLE,  32'h0000_0000, 32'h0000_0000, WORD, 1'b0, 32'h0000_0000, 1'b0},
    '{OP_IDLE,  32'h0000_0000, 32'h0000_0000, WORD, 1'b0, 32'h0000_0000, 1'b0},
    '{OP_STORE, 32'h0000_1000, 32'hC0DE_0000, WORD, 1'b0, 32'h0000_0000, 1'b0},
    '{OP_STORE, 32'h0000_1004, 32'hC0DE_0001, WORD, 1'b0, 32'h0000_0000, 1'b0},
    '{OP_STORE, 32'h0000_100C, 32'hC0DE_0002, WORD, 1'b0, 32'h0000_0000, 1'b0},
    '{OP_STORE, 32'h0000_2018, 32'hC0DE_0003, WORD, 1'b0, 32'h0000_0000, 1'b0},
    '{OP_STORE, 32'h0000_3024, 32'hC0DE_0004, WORD, 1'b0, 32'h0000_0000, 1'b1}, // Buffer full
    '{OP_LOAD,  32'h0000_100C, 32'h0000_0000, WORD, 1'b1, 32'hC0DE_0002, 1'b0},
    '{OP_IDLE,  32'h0000_0000, 32'h0000_0000, WORD, 1'b0, 32'h0000_0000, 1'b0},
    '{OP_IDLE,  32'h0000_0000, 32'h0000_0000, WORD, 1'b0, 32'h0000_0000, 1'b0},
    '{OP_IDLE,  32'h0000_0000, 32'h0000_0000, WORD, 1'b0, 32'h0000_0000, 1'b0},
    '{OP_IDLE,  32'h0000_0000, 32'h0000_0000, WORD, 1'b0, 32'h0000_0000, 1'b0}
};

`endif

// ==== sim/tl_tb.sv ====
`timescale 1ns/1ns

module tl_tb import tl_pkg::*; ();

    localparam int unsigned DCACHE_LINES = 8;
    localparam int unsigned SB_DEPTH     = 4;

    `include "tl_tb_table.svh"

    localparam int TIMEOUT_CYCLES = 10 + N_ROWS * 12;   // Reset plus a budget per row

    logic                 clk_i = 1'b0;
    logic                 rst_n_i = 1'b0;
    ex_tl_t               ex = '0;
    tl_mem_t              tl_mem;
    logic                 hazard;
    logic                 mmu_miss;
    logic [ADDR_SIZE-1:0] mmu_addr;
    logic                 mmu_wr;
    memop_type_e          mmu_wr_type;
    logic [WORD_SIZE-1:0] mmu_wr_data;
    logic                 mmu_data_rdy = 1'b0;
    logic [ADDR_SIZE-1:0] mmu_fill_addr = '0;

    // Reference model state
    sb_entry_t               sb_model [$];
    logic [ADDR_SIZE-1:0]    fill_q [$];
    logic [DCACHE_LINES-1:0] line_valid = '0;
    logic [ADDR_SIZE-1:0]    line_num [DCACHE_LINES];
    logic                    pending_valid = 1'b0;
    logic [ADDR_SIZE-1:0]    pending_line = '0;
    int                      miss_count = 0;
    int                      drain_count = 0;
    int                      cycle_count = 0;

    always #2 clk_i = ~clk_i;

    tl_top #(
        .DCACHE_LINES (DCACHE_LINES),
        .SB_DEPTH     (SB_DEPTH)
    ) i_dut (
        .clk_i             (clk_i),
        .rst_n_i           (rst_n_i),
        .ex_i              (ex),
        .tl_mem_o          (tl_mem),
        .pipeline_hazard_o (hazard),
        .mmu_miss_o        (mmu_miss),
        .mmu_addr_o        (mmu_addr),
        .mmu_wr_o          (mmu_wr),
        .mmu_wr_type_o     (mmu_wr_type),
        .mmu_data_o        (mmu_wr_data),
        .mmu_data_rdy_i    (mmu_data_rdy),
        .mmu_addr_i        (mmu_fill_addr)
    );

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("TESTBENCH FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            fail_run($sformatf("error: %s expected %0h actual %0h", name, expected, actual));
        end
    endtask

    function automatic logic [ADDR_SIZE-1:0] line_of(input logic [ADDR_SIZE-1:0] addr);
        return addr >> DCACHE_OFFSET_SIZE;
    endfunction

    function automatic logic line_present(input logic [ADDR_SIZE-1:0] addr);
        int unsigned idx;
        idx = line_of(addr) % DCACHE_LINES;
        return line_valid[idx] && (line_num[idx] == line_of(addr));
    endfunction

    function automatic logic fill_pending_for(input logic [ADDR_SIZE-1:0] addr);
        return pending_valid && (pending_line == line_of(addr));
    endfunction

    // MMU model, one fill at a time after 2 to 6 cycles
    initial begin
        int unsigned wait_cycles;
        wait_cycles = 0;
        void'($urandom(66));
        forever begin
            @(negedge clk_i);
            mmu_data_rdy = 1'b0;
            if (wait_cycles != 0) begin
                wait_cycles--;
                if (wait_cycles == 0) begin
                    mmu_data_rdy  = 1'b1;
                    mmu_fill_addr = fill_q.pop_front();
                end
            end else if (fill_q.size() != 0) begin
                wait_cycles = 2 + ($urandom % 5);
            end
        end
    end

    // Tracks fills and drains at each edge
    always @(posedge clk_i) begin
        sb_entry_t head;
        if (rst_n_i) begin
            if (tl_mem.sb_flush) begin
                if (sb_model.size() == 0) begin
                    fail_run("a drain appeared while no store was left in the buffer");
                end else begin
                    head = sb_model.pop_front();
                    check_value($sformatf("drain %0d addr", drain_count), head.addr,
                                tl_mem.sb_addr);
                    check_value($sformatf("drain %0d data", drain_count), head.data,
                                tl_mem.sb_data_flush);
                    check_value($sformatf("drain %0d type", drain_count), head.memop_type,
                                tl_mem.sb_type_flush);
                    drain_count++;
                end
            end
            if (mmu_data_rdy) begin
                line_valid[line_of(mmu_fill_addr) % DCACHE_LINES] = 1'b1;
                line_num[line_of(mmu_fill_addr) % DCACHE_LINES]   = line_of(mmu_fill_addr);
                pending_valid = 1'b0;
            end
            if (mmu_miss) begin
                check_value("fill request address", ex.alu_res, mmu_addr);
                miss_count++;
                pending_valid = 1'b1;
                pending_line  = line_of(ex.alu_res);
                fill_q.push_back(mmu_addr);
            end
        end
    end

    always @(posedge clk_i) begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES) begin
            fail_run($sformatf("timeout, the run did not finish in %0d cycles", TIMEOUT_CYCLES));
        end
    end

    always @(negedge clk_i) begin
        if (i_dut.i_tl_stage.i_tl_assert.fail_count != 0) begin
            fail_run("a bound assertion failed during the run");
        end
    end

    task automatic check_reset();
        check_value("reset hazard", 0, hazard);
        check_value("reset mmu_miss", 0, mmu_miss);
        check_value("reset mmu_wr", 0, mmu_wr);
        check_value("reset memop bits", 0, {tl_mem.memop_rd, tl_mem.memop_wr});
        check_value("reset sb_flush", 0, tl_mem.sb_flush);
    endtask

    // Drives one row at the falling edge and holds it through the stall
    task automatic apply_row(input int r);
        stim_row_t            row;
        logic                 hz;
        logic                 wr;
        logic [ADDR_SIZE-1:0] wr_addr;
        logic [WORD_SIZE-1:0] wr_data;
        memop_type_e          wr_type;
        logic                 stalled;
        int                   misses_before;
        int                   exp_misses;
        string                name;
        row  = STIM_TABLE[r];
        name = $sformatf("row %0d", r);
        ex.alu_res    = row.addr;
        ex.rf_we      = (row.kind == OP_LOAD);
        ex.rf_waddr   = REG_SIZE'(r + 1);
        ex.st_data    = row.data;
        ex.memop_rd   = (row.kind == OP_LOAD);
        ex.memop_wr   = (row.kind == OP_STORE);
        ex.memop_type = row.memop_type;
        ex.tkbr       = r[0];   // Odd rows carry a taken branch
        ex.new_pc     = 32'h0000_0100 + 4 * r;
        exp_misses = (row.kind != OP_IDLE) && !line_present(row.addr) &&
                     !fill_pending_for(row.addr) && !(row.kind == OP_LOAD && row.exp_sb_hit);
        misses_before = miss_count;
        stalled       = 1'b0;
        do begin
            @(posedge clk_i);
            hz      = hazard;
            wr      = mmu_wr;
            wr_addr = mmu_addr;
            wr_data = mmu_wr_data;
            wr_type = mmu_wr_type;
            @(negedge clk_i);
            if (hz) begin
                stalled = 1'b1;
                check_value({name, " write-through in stall"}, 0, wr);
                check_value({name, " bubble"}, 0,
                            {tl_mem.rf_we, tl_mem.memop_rd, tl_mem.memop_wr, tl_mem.tkbr});
            end
        end while (hz);
        check_value({name, " stall"}, row.exp_stall, stalled);
        check_value({name, " fill requests"}, exp_misses, miss_count - misses_before);
        check_value({name, " write-through"}, row.kind == OP_STORE, wr);
        check_value({name, " tkbr"}, r[0], tl_mem.tkbr);
        if (row.kind == OP_STORE) begin
            check_value({name, " write-through addr"}, row.addr, wr_addr);
            check_value({name, " write-through data"}, row.data, wr_data);
            check_value({name, " write-through type"}, row.memop_type, wr_type);
            sb_model.push_back('{addr: row.addr, data: row.data, memop_type: row.memop_type});
        end
        if (row.kind == OP_IDLE) begin
            check_value({name, " sb_flush"}, sb_model.size() != 0, tl_mem.sb_flush);
            check_value({name, " memop bits"}, 0, {tl_mem.memop_rd, tl_mem.memop_wr});
        end else begin
            check_value({name, " alu_res"}, row.addr, tl_mem.alu_res);
            check_value({name, " rf_we"}, row.kind == OP_LOAD, tl_mem.rf_we);
            check_value({name, " rf_waddr"}, r + 1, tl_mem.rf_waddr);
            check_value({name, " new_pc"}, 32'h0000_0100 + 4 * r, tl_mem.new_pc);
            check_value({name, " memop_type"}, row.memop_type, tl_mem.memop_type);
            check_value({name, " addr_index"}, line_of(row.addr) % DCACHE_LINES,
                        tl_mem.addr_index);
            check_value({name, " memop_wr"}, row.kind == OP_STORE, tl_mem.memop_wr);
            check_value({name, " memop_rd"}, row.kind == OP_LOAD && !row.exp_sb_hit,
                        tl_mem.memop_rd);
            check_value({name, " sb_hit"}, row.exp_sb_hit, tl_mem.sb_hit);
            if (row.exp_sb_hit) check_value({name, " sb_data_load"}, row.exp_data,
                                            tl_mem.sb_data_load);
        end
    endtask

    initial begin
        repeat (10) @(posedge clk_i);
        @(negedge clk_i);
        rst_n_i = 1'b1;
        check_reset();
        for (int r = 0; r < N_ROWS; r++) begin
            apply_row(r);
        end
        ex = '0;
        check_value("stores left undrained", 0, sb_model.size());
        if (i_dut.i_tl_stage.i_tl_assert.fail_count != 0) begin
            fail_run("a bound assertion failed during the run");
        end else begin
            $display("TESTBENCH PASSED");
            $finish;
        end
    end

endmodule

// ==== sim/tl_assert.sv ====
`timescale 1ns/1ns

module tl_assert import tl_pkg::*; (
    input logic      clk_i,
    input logic      rst_n_i,
    input tl_state_e state_i,
    input logic      mmu_miss_i,
    input logic      mmu_data_rdy_i,
    input logic      hazard_i,
    input logic      drain_i,
    input logic      mem_op_i
);

    int unsigned fail_count = 0;   // Failed assertions so far

    // Fill requests start only from idle
    a_miss_from_idle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        mmu_miss_i |-> (state_i == TL_IDLE))
        else begin
            fail_count++;
            $error("fill request while the stage is not idle");
        end

    // Stalled load hits on the refilled line
    a_release_after_fill: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (state_i == HAZARD_DC_MISS && mmu_data_rdy_i) |=> !hazard_i)
        else begin
            fail_count++;
            $error("hazard still high one cycle after the line fill");
        end

    a_no_drain_on_accept: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(drain_i && mem_op_i && !hazard_i))
        else begin
            fail_count++;
            $error("store buffer drain in the same cycle as an accepted memop");
        end

endmodule

bind tl_stage tl_assert i_tl_assert (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .state_i        (state_q),
    .mmu_miss_i     (mmu_miss_o),
    .mmu_data_rdy_i (mmu_data_rdy_i),
    .hazard_i       (hazard),
    .drain_i        (drain),
    .mem_op_i       (mem_op)
);

// ==== src/tl_top.sv ====
`timescale 1ns/1ns

module tl_top import tl_pkg::*; #(
    parameter int unsigned DCACHE_LINES = DCACHE_LINES_DEF,
    parameter int unsigned SB_DEPTH     = SB_DEPTH_DEF
) (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  ex_tl_t               ex_i,
    output tl_mem_t              tl_mem_o,
    output logic                 pipeline_hazard_o,
    output logic                 mmu_miss_o,
    output logic [ADDR_SIZE-1:0] mmu_addr_o,
    output logic                 mmu_wr_o,
    output memop_type_e          mmu_wr_type_o,
    output logic [WORD_SIZE-1:0] mmu_data_o,
    input  logic                 mmu_data_rdy_i,
    input  logic [ADDR_SIZE-1:0] mmu_addr_i
);

    localparam int unsigned INDEX_SIZE = $clog2(DCACHE_LINES);

    logic                  dc_req;
    logic [ADDR_SIZE-1:0]  dc_addr;
    logic                  dc_hit;
    logic                  dc_miss;
    logic [INDEX_SIZE-1:0] dc_index;

    logic                 sb_store;
    logic                 sb_load;
    logic                 sb_drain;
    logic [ADDR_SIZE-1:0] sb_addr;
    logic [WORD_SIZE-1:0] sb_data;
    memop_type_e          sb_type;
    logic                 sb_hit;
    logic                 sb_miss;
    logic                 sb_full;
    logic                 sb_head_valid;
    sb_entry_t            sb_head;
    logic [WORD_SIZE-1:0] sb_load_data;

    tl_stage #(
        .DCACHE_LINES (DCACHE_LINES)
    ) i_tl_stage (
        .clk_i             (clk_i),
        .rst_n_i           (rst_n_i),
        .ex_i              (ex_i),
        .pipeline_hazard_o (pipeline_hazard_o),
        .tl_mem_o          (tl_mem_o),
        .mmu_miss_o        (mmu_miss_o),
        .mmu_addr_o        (mmu_addr_o),
        .mmu_wr_o          (mmu_wr_o),
        .mmu_wr_type_o     (mmu_wr_type_o),
        .mmu_data_o        (mmu_data_o),
        .mmu_data_rdy_i    (mmu_data_rdy_i),
        .dc_req_o          (dc_req),
        .dc_addr_o         (dc_addr),
        .dc_hit_i          (dc_hit),
        .dc_miss_i         (dc_miss),
        .dc_index_i        (dc_index),
        .sb_store_o        (sb_store),
        .sb_load_o         (sb_load),
        .sb_drain_o        (sb_drain),
        .sb_addr_o         (sb_addr),
        .sb_data_o         (sb_data),
        .sb_type_o         (sb_type),
        .sb_hit_i          (sb_hit),
        .sb_miss_i         (sb_miss),
        .sb_full_i         (sb_full),
        .sb_head_valid_i   (sb_head_valid),
        .sb_head_i         (sb_head),
        .sb_load_data_i    (sb_load_data)
    );

    // Fills come straight from the MMU reply
    dcache_tag #(
        .DCACHE_LINES (DCACHE_LINES)
    ) i_dcache_tag (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .req_i         (dc_req),
        .lookup_addr_i (dc_addr),
        .fill_i        (mmu_data_rdy_i),
        .fill_addr_i   (mmu_addr_i),
        .hit_o         (dc_hit),
        .miss_o        (dc_miss),
        .index_o       (dc_index)
    );

    store_buffer #(
        .SB_DEPTH (SB_DEPTH)
    ) i_store_buffer (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .store_i      (sb_store),
        .load_i       (sb_load),
        .drain_i      (sb_drain),
        .addr_i       (sb_addr),
        .data_i       (sb_data),
        .type_i       (sb_type),
        .hit_o        (sb_hit),
        .miss_o       (sb_miss),
        .full_o       (sb_full),
        .head_valid_o (sb_head_valid),
        .head_o       (sb_head),
        .load_data_o  (sb_load_data)
    );

endmodule

// ==== src/tl_stage.sv ====
`timescale 1ns/1ns

module tl_stage import tl_pkg::*; #(
    parameter int unsigned DCACHE_LINES = DCACHE_LINES_DEF,
    localparam int unsigned INDEX_SIZE  = $clog2(DCACHE_LINES)
) (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    // EX side
    input  ex_tl_t                ex_i,
    output logic                  pipeline_hazard_o,
    // MEM side
    output tl_mem_t               tl_mem_o,
    // MMU
    output logic                  mmu_miss_o,
    output logic [ADDR_SIZE-1:0]  mmu_addr_o,
    output logic                  mmu_wr_o,
    output memop_type_e           mmu_wr_type_o,
    output logic [WORD_SIZE-1:0]  mmu_data_o,
    input  logic                  mmu_data_rdy_i,
    // Tag array
    output logic                  dc_req_o,
    output logic [ADDR_SIZE-1:0]  dc_addr_o,
    input  logic                  dc_hit_i,
    input  logic                  dc_miss_i,
    input  logic [INDEX_SIZE-1:0] dc_index_i,
    // Store buffer
    output logic                  sb_store_o,
    output logic                  sb_load_o,
    output logic                  sb_drain_o,
    output logic [ADDR_SIZE-1:0]  sb_addr_o,
    output logic [WORD_SIZE-1:0]  sb_data_o,
    output memop_type_e           sb_type_o,
    input  logic                  sb_hit_i,
    input  logic                  sb_miss_i,
    input  logic                  sb_full_i,
    input  logic                  sb_head_valid_i,
    input  sb_entry_t             sb_head_i,
    input  logic [WORD_SIZE-1:0]  sb_load_data_i
);

    localparam int unsigned TAG_SIZE = ADDR_SIZE - INDEX_SIZE - DCACHE_OFFSET_SIZE;

    tl_state_e state_q;
    tl_state_e state_d;

    logic [TAG_SIZE-1:0] mif_tag_q;   // Tag of the store miss being filled
    logic [TAG_SIZE-1:0] ex_tag;
    logic                same_tag;
    logic                mem_op;
    logic                lookup_en;
    logic                hazard;
    logic                drain;
    logic                fill_req;
    logic                accept_wr;
    tl_mem_t             tl_mem_q;

    assign ex_tag    = ex_i.alu_res[ADDR_SIZE-1 -: TAG_SIZE];
    assign same_tag  = (mif_tag_q == ex_tag);
    assign mem_op    = ex_i.memop_rd | ex_i.memop_wr;
    assign lookup_en = (state_q == TL_IDLE) || (state_q == MISS_IN_FLIGHT);
    assign accept_wr = ex_i.memop_wr & ~hazard;

    assign dc_req_o  = lookup_en & mem_op;
    assign dc_addr_o = ex_i.alu_res;

    assign sb_store_o = accept_wr;
    assign sb_load_o  = lookup_en & ex_i.memop_rd;
    assign sb_drain_o = drain;
    assign sb_addr_o  = ex_i.alu_res;
    assign sb_data_o  = ex_i.st_data;
    assign sb_type_o  = ex_i.memop_type;

    // Fill requests and write-through share the address bus
    assign mmu_miss_o    = fill_req;
    assign mmu_addr_o    = ex_i.alu_res;
    assign mmu_wr_o      = accept_wr;
    assign mmu_wr_type_o = ex_i.memop_type;
    assign mmu_data_o    = ex_i.st_data;

    assign pipeline_hazard_o = hazard;
    assign tl_mem_o          = tl_mem_q;

    always_comb begin
        state_d  = state_q;
        hazard   = 1'b0;
        drain    = 1'b0;
        fill_req = 1'b0;
        unique case (state_q)
            TL_IDLE: begin
                if (ex_i.memop_wr) begin
                    if (sb_full_i) begin
                        hazard  = 1'b1;
                        state_d = HAZARD_SB_FULL;
                    end else if (dc_miss_i) begin
                        fill_req = 1'b1;   // Store goes on, line fill starts
                        state_d  = MISS_IN_FLIGHT;
                    end
                end else if (ex_i.memop_rd) begin
                    if (dc_miss_i && sb_miss_i) begin
                        hazard   = 1'b1;
                        fill_req = 1'b1;
                        state_d  = HAZARD_DC_MISS;
                    end
                end else begin
                    drain = sb_head_valid_i;
                end
            end
            MISS_IN_FLIGHT: begin
                if (ex_i.memop_wr) begin
                    hazard = dc_hit_i | ~same_tag | sb_full_i;
                end else if (ex_i.memop_rd) begin
                    hazard = dc_miss_i & (~same_tag | sb_miss_i);
                end else begin
                    drain = sb_head_valid_i;
                end
                if (mmu_data_rdy_i) state_d = TL_IDLE;
            end
            HAZARD_DC_MISS: begin
                hazard = 1'b1;
                if (mmu_data_rdy_i) state_d = TL_IDLE;
            end
            HAZARD_SB_FULL: begin
                hazard = 1'b1;
                drain  = sb_head_valid_i;   // Make room for the held store
                if (!sb_full_i) state_d = TL_IDLE;
            end
            default: state_d = TL_IDLE;
        endcase
    end

    // Only read in MISS_IN_FLIGHT, entered straight from idle
    always_ff @(posedge clk_i) begin
        if (state_q == TL_IDLE) mif_tag_q <= ex_tag;
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q           <= TL_IDLE;
            tl_mem_q.rf_we    <= 1'b0;
            tl_mem_q.memop_rd <= 1'b0;
            tl_mem_q.memop_wr <= 1'b0;
            tl_mem_q.tkbr     <= 1'b0;
            tl_mem_q.sb_hit   <= 1'b0;
            tl_mem_q.sb_flush <= 1'b0;
        end else begin
            state_q <= state_d;
            if (!hazard) begin
                tl_mem_q.alu_res      <= ex_i.alu_res;
                tl_mem_q.rf_we        <= ex_i.rf_we;
                tl_mem_q.rf_waddr     <= ex_i.rf_waddr;
                tl_mem_q.memop_rd     <= ex_i.memop_rd & ~sb_hit_i;   // Forwarded load skips cache
                tl_mem_q.memop_wr     <= ex_i.memop_wr;
                tl_mem_q.memop_type   <= ex_i.memop_type;
                tl_mem_q.tkbr         <= ex_i.tkbr;
                tl_mem_q.new_pc       <= ex_i.new_pc;
                tl_mem_q.addr_index   <= INDEX_FIELD_SIZE'(dc_index_i);
                tl_mem_q.sb_hit       <= sb_hit_i;
                tl_mem_q.sb_data_load <= sb_load_data_i;
            end else begin
                // Bubble toward MEM
                tl_mem_q.rf_we    <= 1'b0;
                tl_mem_q.memop_rd <= 1'b0;
                tl_mem_q.memop_wr <= 1'b0;
                tl_mem_q.tkbr     <= 1'b0;
                tl_mem_q.sb_hit   <= 1'b0;
            end
            tl_mem_q.sb_flush <= drain;
            if (drain) begin
                tl_mem_q.sb_addr       <= sb_head_i.addr;
                tl_mem_q.sb_data_flush <= sb_head_i.data;
                tl_mem_q.sb_type_flush <= sb_head_i.memop_type;
            end
        end
    end

endmodule

// ==== src/store_buffer.sv ====
`timescale 1ns/1ns

// Circular FIFO of stores waiting to be written into the data cache.
// SB_DEPTH must be a power of two so the pointers wrap on their own.
module store_buffer import tl_pkg::*; #(
    parameter int unsigned SB_DEPTH = SB_DEPTH_DEF
) (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 store_i,
    input  logic                 load_i,
    input  logic                 drain_i,
    input  logic [ADDR_SIZE-1:0] addr_i,
    input  logic [WORD_SIZE-1:0] data_i,
    input  memop_type_e          type_i,
    output logic                 hit_o,
    output logic                 miss_o,
    output logic                 full_o,
    output logic                 head_valid_o,
    output sb_entry_t            head_o,
    output logic [WORD_SIZE-1:0] load_data_o
);

    localparam int unsigned PTR_SIZE = $clog2(SB_DEPTH);

    sb_entry_t entries_q [SB_DEPTH];

    logic [PTR_SIZE-1:0] head_q;
    logic [PTR_SIZE-1:0] tail_q;
    logic [PTR_SIZE:0]   count_q;

    logic                 push;
    logic                 pop;
    logic                 match_found;
    logic                 match_word;
    logic [WORD_SIZE-1:0] match_data;

    assign full_o       = (count_q == (PTR_SIZE + 1)'(SB_DEPTH));
    assign head_valid_o = (count_q != '0);
    assign head_o       = entries_q[head_q];

    assign push = store_i & ~full_o;
    assign pop  = drain_i & head_valid_o;

    // Walk from oldest to youngest so the last match is the youngest one
    always_comb begin
        logic [PTR_SIZE-1:0] ptr;
        match_found = 1'b0;
        match_word  = 1'b0;
        match_data  = '0;
        for (int i = 0; i < SB_DEPTH; i++) begin
            ptr = head_q + PTR_SIZE'(i);
            if ((i < count_q) &&
                (entries_q[ptr].addr[ADDR_SIZE-1:WORD_OFFSET_SIZE] ==
                 addr_i[ADDR_SIZE-1:WORD_OFFSET_SIZE])) begin
                match_found = 1'b1;
                match_word  = (entries_q[ptr].memop_type == WORD);
                match_data  = entries_q[ptr].data;
            end
        end
    end

    // A partial store to the word cannot supply the whole load
    assign hit_o       = load_i & match_found & match_word;
    assign miss_o      = load_i & ~hit_o;
    assign load_data_o = match_data;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (push) tail_q <= tail_q + 1'b1;
            if (pop)  head_q <= head_q + 1'b1;
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;   // Idle or push and pop together
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            entries_q[tail_q] <= '{addr: addr_i, data: data_i, memop_type: type_i};
        end
    end

endmodule

// ==== src/dcache_tag.sv ====
`timescale 1ns/1ns

module dcache_tag import tl_pkg::*; #(
    parameter int unsigned DCACHE_LINES = DCACHE_LINES_DEF,
    localparam int unsigned INDEX_SIZE  = $clog2(DCACHE_LINES)
) (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    // Lookup from the TL stage
    input  logic                  req_i,
    input  logic [ADDR_SIZE-1:0]  lookup_addr_i,
    // Line fill from the MMU
    input  logic                  fill_i,
    input  logic [ADDR_SIZE-1:0]  fill_addr_i,
    output logic                  hit_o,
    output logic                  miss_o,
    output logic [INDEX_SIZE-1:0] index_o
);

    localparam int unsigned TAG_SIZE = ADDR_SIZE - INDEX_SIZE - DCACHE_OFFSET_SIZE;

    logic [TAG_SIZE-1:0]     tags_q [DCACHE_LINES];
    logic [DCACHE_LINES-1:0] valid_q;

    logic [INDEX_SIZE-1:0] lookup_index;
    logic [INDEX_SIZE-1:0] fill_index;
    logic [TAG_SIZE-1:0]   lookup_tag;
    logic [TAG_SIZE-1:0]   fill_tag;
    logic                  tag_match;

    assign lookup_index = lookup_addr_i[DCACHE_OFFSET_SIZE +: INDEX_SIZE];
    assign lookup_tag   = lookup_addr_i[ADDR_SIZE-1 -: TAG_SIZE];
    assign fill_index   = fill_addr_i[DCACHE_OFFSET_SIZE +: INDEX_SIZE];
    assign fill_tag     = fill_addr_i[ADDR_SIZE-1 -: TAG_SIZE];

    assign tag_match = valid_q[lookup_index] && (tags_q[lookup_index] == lookup_tag);

    assign hit_o   = req_i & tag_match;
    assign miss_o  = req_i & ~tag_match;   // Only a real request can miss
    assign index_o = lookup_index;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;   // All lines invalid
        end else if (fill_i) begin
            valid_q[fill_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (fill_i) begin
            tags_q[fill_index] <= fill_tag;
        end
    end

endmodule

// ==== src/tl_pkg.sv ====
package tl_pkg;

    localparam int unsigned ADDR_SIZE         = 32;
    localparam int unsigned WORD_SIZE         = 32;
    localparam int unsigned REG_SIZE          = 5;
    localparam int unsigned DCACHE_LINE_BYTES = 16;

    localparam int unsigned DCACHE_OFFSET_SIZE = $clog2(DCACHE_LINE_BYTES);
    localparam int unsigned WORD_OFFSET_SIZE   = $clog2(WORD_SIZE / 8);

    // Defaults for the top level parameters
    localparam int unsigned DCACHE_LINES_DEF = 8;
    localparam int unsigned SB_DEPTH_DEF     = 4;

    // Room for the line index toward MEM, up to 256 lines
    localparam int unsigned INDEX_FIELD_SIZE = 8;

    typedef enum logic [1:0] {
        BYTE = 2'b00,
        HALF = 2'b01,
        WORD = 2'b10
    } memop_type_e;

    typedef enum logic [1:0] {
        TL_IDLE,
        MISS_IN_FLIGHT,
        HAZARD_DC_MISS,
        HAZARD_SB_FULL
    } tl_state_e;

    typedef struct packed {
        logic [ADDR_SIZE-1:0] alu_res;   // Effective address
        logic                 rf_we;
        logic [REG_SIZE-1:0]  rf_waddr;
        logic [WORD_SIZE-1:0] st_data;
        logic                 memop_rd;
        logic                 memop_wr;
        memop_type_e          memop_type;
        logic                 tkbr;
        logic [WORD_SIZE-1:0] new_pc;
    } ex_tl_t;

    typedef struct packed {
        logic [ADDR_SIZE-1:0]        alu_res;
        logic                        rf_we;
        logic [REG_SIZE-1:0]         rf_waddr;
        logic                        memop_rd;
        logic                        memop_wr;
        memop_type_e                 memop_type;
        logic                        tkbr;
        logic [WORD_SIZE-1:0]        new_pc;
        logic [INDEX_FIELD_SIZE-1:0] addr_index;
        logic                        sb_hit;
        logic [WORD_SIZE-1:0]        sb_data_load;
        // Drained store buffer entry
        logic                        sb_flush;
        logic [ADDR_SIZE-1:0]        sb_addr;
        logic [WORD_SIZE-1:0]        sb_data_flush;
        memop_type_e                 sb_type_flush;
    } tl_mem_t;

    typedef struct packed {
        logic [ADDR_SIZE-1:0] addr;
        logic [WORD_SIZE-1:0] data;
        memop_type_e          memop_type;
    } sb_entry_t;

endpackage
